//--- files.f
rtl/rv_dec_pkg.sv
rtl/register_file.sv
rtl/decode.sv
rtl/id_stage.sv
sim/tb_clk_gen.sv
sim/id_stage_asserts.sv
sim/tb_id_stage.sv

//--- Makefile
# Verilator build and run of the decode subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_id_stage.sv
/*
 * Directed testbench for the decode subsystem
 * Reference decoder, per-type compare tasks and an LFSR for random fields
 */
`timescale 1ns/1ps

module tb_id_stage;
  localparam int PERIOD_NS   = 4;
  localparam int TEST_CYCLES = 160;
  localparam int MARGIN      = 100;

  logic                   clk;
  logic                   rst_n;
  logic                   jump_i;
  rv_dec_pkg::pc_t        pc_jump_i;
  logic                   fetch_valid_i;
  logic                   fetch_ready_o;
  rv_dec_pkg::instr_raw_t fetch_instr_i;
  rv_dec_pkg::s_wb_t      wb_i;
  rv_dec_pkg::s_id_ex_t   id_ex_o;
  rv_dec_pkg::rdata_t     rs1_data_o;
  rv_dec_pkg::rdata_t     rs2_data_o;
  logic                   id_valid_o;
  logic                   id_ready_i;

  rv_dec_pkg::rdata_t regs [32];
  rv_dec_pkg::pc_t    exp_pc;
  logic               seen;
  logic [31:0]        lfsr_q = 32'h89cf;
  int                 err_cnt;
  int                 test_cnt;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  id_stage UUT (
    .clk(clk), .rst_n_i(rst_n), .jump_i(jump_i), .pc_jump_i(pc_jump_i),
    .fetch_valid_i(fetch_valid_i), .fetch_ready_o(fetch_ready_o),
    .fetch_instr_i(fetch_instr_i), .wb_i(wb_i), .id_ex_o(id_ex_o),
    .rs1_data_o(rs1_data_o), .rs2_data_o(rs2_data_o),
    .id_valid_o(id_valid_o), .id_ready_i(id_ready_i)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic rv_dec_pkg::pc_t advance_pc();
    if (seen) begin
      exp_pc = exp_pc + 32'd4;
    end
    seen = 1'b1;
    return exp_pc;
  endfunction

  function automatic rv_dec_pkg::rdata_t ref_imm(rv_dec_pkg::instr_raw_t w,
                                                 rv_dec_pkg::imm_kind_t k);
    logic signed [31:0] v;
    case (k)
      rv_dec_pkg::I_IMM:   v = $signed(w) >>> 20;
      rv_dec_pkg::S_IMM:   v = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
      rv_dec_pkg::B_IMM:   v = $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
      rv_dec_pkg::U_IMM:   v = {w[31:12], 12'b0};
      rv_dec_pkg::J_IMM:   v = $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
      rv_dec_pkg::CSR_IMM: v = {27'b0, w[19:15]};
      default:             v = '0;
    endcase
    return v;
  endfunction

  function automatic rv_dec_pkg::s_id_ex_t ref_decode(rv_dec_pkg::instr_raw_t w,
                                                      rv_dec_pkg::pc_t pc);
    rv_dec_pkg::s_id_ex_t e;
    logic                 bad;
    logic [2:0]           f3;
    e = '0;
    bad = 1'b0;
    f3 = w[14:12];
    e.rd_addr  = w[11:7];
    e.rs1_addr = w[19:15];
    e.rs2_addr = w[24:20];
    e.pc_dec   = pc;
    case (w[6:0])
      7'b0010011: begin
        e.f3     = f3;
        e.rs1_op = rv_dec_pkg::REG_RF;
        e.rs2_op = rv_dec_pkg::IMM;
        e.imm    = ref_imm(w, rv_dec_pkg::I_IMM);
        e.rshift = w[30];
        e.we_rd  = 1'b1;
      end
      7'b0110111, 7'b0010111: begin
        e.rs1_op = w[5] ? rv_dec_pkg::ZERO : rv_dec_pkg::PC;
        e.rs2_op = rv_dec_pkg::IMM;
        e.imm    = ref_imm(w, rv_dec_pkg::U_IMM);
        e.we_rd  = 1'b1;
      end
      7'b0110011: begin
        e.f3     = f3;
        e.f7     = w[30] ? 7'h20 : 7'h00;
        e.rshift = w[30];
        e.rs1_op = rv_dec_pkg::REG_RF;
        e.rs2_op = rv_dec_pkg::REG_RF;
        e.we_rd  = 1'b1;
      end
      7'b1101111, 7'b1100111: begin
        e.jump   = 1'b1;
        e.rs2_op = rv_dec_pkg::IMM;
        e.we_rd  = 1'b1;
        e.rs1_op = w[3] ? rv_dec_pkg::PC : rv_dec_pkg::REG_RF;
        e.imm    = ref_imm(w, w[3] ? rv_dec_pkg::J_IMM : rv_dec_pkg::I_IMM);
      end
      7'b1100011: begin
        e.branch = 1'b1;
        e.f3     = f3;
        e.imm    = ref_imm(w, rv_dec_pkg::B_IMM);
        e.rs1_op = rv_dec_pkg::REG_RF;
        e.rs2_op = rv_dec_pkg::REG_RF;
      end
      7'b0000011, 7'b0100011: begin
        e.lsu    = w[5] ? rv_dec_pkg::LSU_STORE : rv_dec_pkg::LSU_LOAD;
        e.lsu_w  = rv_dec_pkg::lsu_w_t'(f3[1:0]);
        e.we_rd  = !w[5];
        e.rs1_op = rv_dec_pkg::REG_RF;
        e.rs2_op = rv_dec_pkg::IMM;
        e.imm    = ref_imm(w, w[5] ? rv_dec_pkg::S_IMM : rv_dec_pkg::I_IMM);
      end
      7'b0001111: begin
        e.rs1_op = rv_dec_pkg::ZERO;
        e.rs2_op = rv_dec_pkg::ZERO;
      end
      7'b1110011: begin
        e.rs1_op = rv_dec_pkg::ZERO;
        e.rs2_op = rv_dec_pkg::ZERO;
        e.imm    = ref_imm(w, rv_dec_pkg::CSR_IMM);
        if (f3 != 3'b000 && f3 != 3'b100) begin
          e.rs1_op        = rv_dec_pkg::REG_RF;
          e.csr.op        = f3[1:0];
          e.csr.addr      = w[31:20];
          e.csr.rs1_is_x0 = (w[19:15] == 5'd0);
          e.we_rd         = (w[11:7] != 5'd0);
        end
        else if (w[19:7] == 13'd0) begin
          case (w[31:20])
            12'h000: e.ecall = 1'b1;
            12'h001: e.ebreak = 1'b1;
            12'h302: e.mret = 1'b1;
            12'h105: e.wfi = 1'b1;
            default: bad = 1'b1;
          endcase
        end
        else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      e.trap.active  = 1'b1;
      e.trap.mtval   = w;
      e.trap.pc_addr = pc;
    end
    return e;
  endfunction

  task automatic check_rec(input string name, input rv_dec_pkg::s_id_ex_t exp,
                           input rv_dec_pkg::s_id_ex_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_data(input string name, input rv_dec_pkg::rdata_t exp,
                            input rv_dec_pkg::rdata_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_pc(input string name, input rv_dec_pkg::pc_t exp,
                          input rv_dec_pkg::pc_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_trap(input string name, input rv_dec_pkg::s_trap_t exp,
                            input rv_dec_pkg::s_trap_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      err_cnt++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic report(input string name, input int start_err);
    test_cnt++;
    $display("%s: %0d errors", name, err_cnt - start_err);
  endtask

  // One instruction through an idle stage and checked a cycle after acceptance
  task automatic send_check(input rv_dec_pkg::instr_raw_t w);
    rv_dec_pkg::s_id_ex_t exp;
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= w;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    exp = ref_decode(w, advance_pc());
    @(negedge clk);
    check_flag("id_valid_o", 1'b1, id_valid_o);
    check_trap("id_ex_o.trap", exp.trap, id_ex_o.trap);
    check_rec("id_ex_o", exp, id_ex_o);
    check_data("rs1_data_o", regs[w[19:15]], rs1_data_o);
    check_data("rs2_data_o", regs[w[24:20]], rs2_data_o);
  endtask

  task automatic do_jump(input rv_dec_pkg::pc_t t);
    rv_dec_pkg::s_id_ex_t exp;
    @(posedge clk);
    jump_i        <= 1'b1;
    pc_jump_i     <= t;
    fetch_valid_i <= 1'b0;
    exp = '0;
    exp.pc_dec = exp_pc;
    @(negedge clk);
    check_rec("id_ex_o", exp, id_ex_o);
    @(posedge clk);
    jump_i <= 1'b0;
    exp_pc = t;
    seen = 1'b0;
  endtask

  task automatic decode_test();
    logic [6:0]         ops [10];
    rv_dec_pkg::rdata_t v;
    int                 e0;
    e0 = err_cnt;
    ops = '{7'h13, 7'h37, 7'h17, 7'h33, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h0f};
    for (int i = 0; i < 32; i++) begin
      v = rand_bits(32);
      @(posedge clk);
      wb_i <= {1'b1, 5'(i), v};
      if (i != 0) begin
        regs[i] = v;
      end
    end
    @(posedge clk);
    wb_i <= '0;
    foreach (ops[i]) begin
      send_check({25'(rand_bits(25)), ops[i]});
    end
    // x0 as rs1 and then the CSR register and immediate forms
    send_check({7'h00, 5'(rand_bits(5)), 5'd0, 3'b000, 5'(rand_bits(5)), 7'h33});
    send_check({17'(rand_bits(17)), 3'b001, 5'(rand_bits(5)), 7'h73});
    send_check({17'(rand_bits(17)), 3'b110, 5'(rand_bits(5)), 7'h73});
    report("decode", e0);
  endtask

  task automatic stream_test();
    rv_dec_pkg::instr_raw_t q [8];
    int                     e0;
    e0 = err_cnt;
    do_jump(rv_dec_pkg::RESET_PC);
    foreach (q[i]) begin
      q[i] = {25'(rand_bits(25)), 7'h13};
    end
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= q[0];
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i < 7) begin
        fetch_instr_i <= q[i + 1];
      end
      else begin
        fetch_valid_i <= 1'b0;
      end
      @(negedge clk);
      check_rec("id_ex_o", ref_decode(q[i], advance_pc()), id_ex_o);
      check_pc("id_ex_o.pc_dec", rv_dec_pkg::RESET_PC + 32'(4 * i), id_ex_o.pc_dec);
      check_data("rs1_data_o", regs[q[i][19:15]], rs1_data_o);
    end
    report("stream", e0);
  endtask

  task automatic backpressure_test();
    rv_dec_pkg::instr_raw_t wa;
    rv_dec_pkg::instr_raw_t wb_w;
    rv_dec_pkg::s_id_ex_t   exp_a;
    int                     e0;
    e0 = err_cnt;
    wa = {25'(rand_bits(25)), 7'h33};
    wb_w = {25'(rand_bits(25)), 7'h13};
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= wa;
    @(posedge clk);
    id_ready_i    <= 1'b0;
    fetch_instr_i <= wb_w;
    exp_a = ref_decode(wa, advance_pc());
    repeat (4) begin
      @(negedge clk);
      check_flag("fetch_ready_o", 1'b0, fetch_ready_o);
      check_flag("id_valid_o", 1'b1, id_valid_o);
      check_rec("id_ex_o", exp_a, id_ex_o);
      check_data("rs1_data_o", regs[wa[19:15]], rs1_data_o);
      check_data("rs2_data_o", regs[wa[24:20]], rs2_data_o);
    end
    @(posedge clk);
    id_ready_i <= 1'b1;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    @(negedge clk);
    check_flag("id_valid_o", 1'b1, id_valid_o);
    check_rec("id_ex_o", ref_decode(wb_w, advance_pc()), id_ex_o);
    @(negedge clk);
    check_flag("id_valid_o", 1'b0, id_valid_o);
    report("backpressure", e0);
  endtask

  task automatic jump_test();
    rv_dec_pkg::pc_t t;
    int              e0;
    e0 = err_cnt;
    send_check({25'(rand_bits(25)), 7'h13});
    t = {30'(rand_bits(30)), 2'b00};
    do_jump(t);
    send_check({25'(rand_bits(25)), 7'h33});
    check_pc("id_ex_o.pc_dec", t, id_ex_o.pc_dec);
    report("jump", e0);
  endtask

  task automatic illegal_test();
    int e0;
    e0 = err_cnt;
    send_check(32'h0000_0000);
    send_check({25'(rand_bits(25)), 7'h7f});
    send_check({25'(rand_bits(25)), 7'h57});
    send_check(32'h0000_4073);
    send_check(32'h0000_01f3);
    send_check(32'h0200_0073);
    send_check(32'h0030_0073);
    send_check(32'h0000_0073);
    send_check(32'h0010_0073);
    send_check(32'h3020_0073);
    report("illegal", e0);
  endtask

  task automatic wfi_test();
    rv_dec_pkg::instr_raw_t w2;
    rv_dec_pkg::s_id_ex_t   exp;
    rv_dec_pkg::pc_t        t;
    int                     e0;
    e0 = err_cnt;
    w2 = {25'(rand_bits(25)), 7'h13};
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_instr_i <= 32'h1050_0073;
    @(posedge clk);
    fetch_instr_i <= w2;
    exp = '0;
    exp.wfi = 1'b1;
    exp.pc_dec = advance_pc();
    repeat (5) begin
      @(negedge clk);
      check_flag("fetch_ready_o", 1'b0, fetch_ready_o);
      check_rec("id_ex_o", exp, id_ex_o);
    end
    t = {30'(rand_bits(30)), 2'b00};
    @(posedge clk);
    jump_i    <= 1'b1;
    pc_jump_i <= t;
    exp.wfi = 1'b0;
    @(negedge clk);
    check_rec("id_ex_o", exp, id_ex_o);
    @(posedge clk);
    jump_i <= 1'b0;
    exp_pc = t;
    seen = 1'b0;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    @(negedge clk);
    check_rec("id_ex_o", ref_decode(w2, advance_pc()), id_ex_o);
    check_pc("id_ex_o.pc_dec", t, id_ex_o.pc_dec);
    report("wfi", e0);
  endtask

  initial begin
    #((TEST_CYCLES + MARGIN) * PERIOD_NS * 1ns);
    $display("Watchdog expired before the tests completed");
    $display("Test failed");
    $finish;
  end

  initial begin
    jump_i = 1'b0;
    pc_jump_i = '0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    wb_i = '0;
    id_ready_i = 1'b1;
    err_cnt = 0;
    test_cnt = 0;
    exp_pc = rv_dec_pkg::RESET_PC;
    seen = 1'b0;
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_flag("id_valid_o", 1'b0, id_valid_o);
    check_flag("fetch_ready_o", id_ready_i, fetch_ready_o);
    decode_test();
    stream_test();
    backpressure_test();
    jump_test();
    illegal_test();
    wfi_test();
    $display("Summary: %0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end
    else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim/id_stage_asserts.sv
/*
 * Handshake, reset and WFI checks for the decode subsystem
 */
`timescale 1ns/1ps

module id_stage_asserts (
  input logic                   clk,
  input logic                   rst_n_i,
  input logic                   jump_i,
  input logic                   id_ready_i,
  input logic                   fetch_valid_i,
  input logic                   fetch_ready_i,
  input rv_dec_pkg::instr_raw_t fetch_instr_i,
  input logic                   id_valid_i,
  input rv_dec_pkg::s_id_ex_t   id_ex_i
);
  localparam rv_dec_pkg::instr_raw_t WFI_WORD = {rv_dec_pkg::F7_WFI, rv_dec_pkg::RS2_WFI,
                                                 5'd0, rv_dec_pkg::F3_PRIV, 5'd0,
                                                 rv_dec_pkg::RV_SYSTEM};

  logic wfi_held_ff;

  // WFI seen on the fetch handshake and not yet released by a jump
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wfi_held_ff <= 1'b0;
    end
    else if (fetch_valid_i && fetch_ready_i && (fetch_instr_i == WFI_WORD)) begin
      wfi_held_ff <= 1'b1;
    end
    else if (jump_i) begin
      wfi_held_ff <= 1'b0;
    end
  end

  // Output register comes out of reset empty
  a_reset_empty: assert property (@(posedge clk) !rst_n_i |=> !id_valid_i)
    else $error("id_valid_o high after reset");

  // A stalled output holds unless a jump flushes it
  a_hold_stable: assert property (@(posedge clk)
    (rst_n_i && id_valid_i && !id_ready_i && !jump_i) |=> (jump_i || $stable(id_ex_i)))
    else $error("id_ex_o changed while stalled");

  // Fetch stays stalled from the cycle after a WFI until the jump
  a_wfi_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wfi_held_ff && !jump_i) |-> !fetch_ready_i)
    else $error("fetch_ready_o high during WFI");

endmodule

bind id_stage id_stage_asserts u_asserts (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .jump_i       (jump_i),
  .id_ready_i   (id_ready_i),
  .fetch_valid_i(fetch_valid_i),
  .fetch_ready_i(fetch_ready_o),
  .fetch_instr_i(fetch_instr_i),
  .id_valid_i   (id_valid_o),
  .id_ex_i      (id_ex_o)
);

//--- sim/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 * 4 ns clock, active-low reset held for the first 2 cycles
 */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  localparam int HALF_PERIOD_PS = 2000;
  localparam int RST_CYCLES     = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_PS * 1ps) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- rtl/id_stage.sv
/*
 * Instruction decode subsystem top
 * Fetch, writeback and execute ports of the decode stage
 */
`timescale 1ns/1ps

module id_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   jump_i,
  input  rv_dec_pkg::pc_t        pc_jump_i,
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  rv_dec_pkg::instr_raw_t fetch_instr_i,
  input  rv_dec_pkg::s_wb_t      wb_i,
  output rv_dec_pkg::s_id_ex_t   id_ex_o,
  output rv_dec_pkg::rdata_t     rs1_data_o,
  output rv_dec_pkg::rdata_t     rs2_data_o,
  output logic                   id_valid_o,
  input  logic                   id_ready_i
);

  decode u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .jump_i       (jump_i),
    .pc_jump_i    (pc_jump_i),
    .fetch_valid_i(fetch_valid_i),
    .fetch_ready_o(fetch_ready_o),
    .fetch_instr_i(fetch_instr_i),
    .wb_i         (wb_i),
    .id_ex_o      (id_ex_o),
    .rs1_data_o   (rs1_data_o),
    .rs2_data_o   (rs2_data_o),
    .id_valid_o   (id_valid_o),
    .id_ready_i   (id_ready_i)
  );

endmodule

//--- rtl/decode.sv
/*
 * Instruction decode stage
 * Valid/ready pipeline register, RV32I decoder, PC tracking,
 * NOP insertion on jump and fetch stall on WFI
 */
`timescale 1ns/1ps

module decode (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   jump_i,
  input  rv_dec_pkg::pc_t        pc_jump_i,
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  input  rv_dec_pkg::instr_raw_t fetch_instr_i,
  input  rv_dec_pkg::s_wb_t      wb_i,
  output rv_dec_pkg::s_id_ex_t   id_ex_o,
  output rv_dec_pkg::rdata_t     rs1_data_o,
  output rv_dec_pkg::rdata_t     rs2_data_o,
  output logic                   id_valid_o,
  input  logic                   id_ready_i
);
  rv_dec_pkg::s_instr_t instr_dec;
  rv_dec_pkg::s_id_ex_t dec_rec;
  rv_dec_pkg::s_id_ex_t id_ex_ff, next_id_ex;
  rv_dec_pkg::pc_t      pc_next;
  logic                 illegal;
  logic                 accept;
  logic                 dec_valid_ff, next_vld_dec;
  logic                 seen_instr_ff, next_seen_instr;
  logic                 wfi_stop_ff, next_wfi_stop;

  assign instr_dec     = rv_dec_pkg::s_instr_t'(fetch_instr_i);
  assign fetch_ready_o = id_ready_i && !wfi_stop_ff;
  assign accept        = fetch_valid_i && fetch_ready_o;
  assign id_valid_o    = dec_valid_ff;

  always_comb begin : dec_op
    dec_rec          = '0;
    illegal          = 1'b0;
    dec_rec.rd_addr  = instr_dec.rd;
    dec_rec.rs1_addr = instr_dec.rs1;
    dec_rec.rs2_addr = instr_dec.rs2;

    case (instr_dec.op)
      rv_dec_pkg::RV_OP_IMM: begin
        dec_rec.f3     = instr_dec.f3;
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::I_IMM);
        dec_rec.rshift = fetch_instr_i[30];
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_LUI: begin
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::ZERO;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::U_IMM);
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_AUIPC: begin
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::PC;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::U_IMM);
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_OP: begin
        dec_rec.f3     = instr_dec.f3;
        dec_rec.f7     = fetch_instr_i[30] ? rv_dec_pkg::F7_ALT : 7'h00;
        dec_rec.rshift = fetch_instr_i[30];
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::REG_RF;
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_JAL: begin
        dec_rec.jump   = 1'b1;
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::PC;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::J_IMM);
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_JALR: begin
        dec_rec.jump   = 1'b1;
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::I_IMM);
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_BRANCH: begin
        dec_rec.branch = 1'b1;
        dec_rec.f3     = instr_dec.f3;
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::REG_RF;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::B_IMM);
      end
      rv_dec_pkg::RV_LOAD: begin
        dec_rec.lsu    = rv_dec_pkg::LSU_LOAD;
        dec_rec.lsu_w  = rv_dec_pkg::lsu_w_t'(instr_dec.f3[1:0]);
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::I_IMM);
        dec_rec.we_rd  = 1'b1;
      end
      rv_dec_pkg::RV_STORE: begin
        dec_rec.lsu    = rv_dec_pkg::LSU_STORE;
        dec_rec.lsu_w  = rv_dec_pkg::lsu_w_t'(instr_dec.f3[1:0]);
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::REG_RF;
        dec_rec.rs2_op = rv_dec_pkg::IMM;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::S_IMM);
      end
      rv_dec_pkg::RV_MISC_MEM: begin
        // Fences retire as plain NOPs
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::ZERO;
        dec_rec.rs2_op = rv_dec_pkg::ZERO;
      end
      rv_dec_pkg::RV_SYSTEM: begin
        dec_rec.f3     = rv_dec_pkg::F3_PRIV;
        dec_rec.rs1_op = rv_dec_pkg::ZERO;
        dec_rec.rs2_op = rv_dec_pkg::ZERO;
        dec_rec.imm    = rv_dec_pkg::gen_imm(fetch_instr_i, rv_dec_pkg::CSR_IMM);
        if ((instr_dec.f3 != rv_dec_pkg::F3_PRIV) && (instr_dec.f3 != rv_dec_pkg::F3_RSVD)) begin
          // CSRRW/S/C and their immediate forms
          dec_rec.rs1_op        = rv_dec_pkg::REG_RF;
          dec_rec.csr.op        = instr_dec.f3[1:0];
          dec_rec.csr.addr      = fetch_instr_i[31:20];
          dec_rec.csr.rs1_is_x0 = (instr_dec.rs1 == '0);
          dec_rec.we_rd         = (instr_dec.rd != '0);
        end
        else if ((instr_dec.f3 == rv_dec_pkg::F3_PRIV) &&
                 (instr_dec.rd == '0) && (instr_dec.rs1 == '0)) begin
          if ((instr_dec.rs2 == rv_dec_pkg::RS2_ECALL) && (instr_dec.f7 == '0)) begin
            dec_rec.ecall = 1'b1;
          end
          else if ((instr_dec.rs2 == rv_dec_pkg::RS2_EBREAK) && (instr_dec.f7 == '0)) begin
            dec_rec.ebreak = 1'b1;
          end
          else if ((instr_dec.rs2 == rv_dec_pkg::RS2_MRET) &&
                   (instr_dec.f7 == rv_dec_pkg::F7_MRET)) begin
            dec_rec.mret = 1'b1;
          end
          else if ((instr_dec.rs2 == rv_dec_pkg::RS2_WFI) &&
                   (instr_dec.f7 == rv_dec_pkg::F7_WFI)) begin
            dec_rec.wfi = 1'b1;
          end
          else begin
            illegal = 1'b1;
          end
        end
        else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    if (illegal) begin
      dec_rec.trap.active = 1'b1;
      dec_rec.trap.mtval  = fetch_instr_i;
    end
  end : dec_op

  always_comb begin : next_state
    // PC of the instruction accepted this cycle
    if (jump_i) begin
      pc_next = pc_jump_i;
    end
    else if (seen_instr_ff) begin
      pc_next = id_ex_ff.pc_dec + 32'd4;
    end
    else begin
      pc_next = id_ex_ff.pc_dec;
    end

    next_id_ex = id_ex_ff;
    if (accept) begin
      next_id_ex        = dec_rec;
      next_id_ex.pc_dec = pc_next;
      if (dec_rec.trap.active) begin
        next_id_ex.trap.pc_addr = pc_next;
      end
    end
    else if (jump_i) begin
      next_id_ex        = '0;
      next_id_ex.pc_dec = pc_jump_i;
    end

    // A held output is dropped by a jump, it is on the wrong path
    next_vld_dec = accept || (dec_valid_ff && !id_ready_i && !jump_i);

    next_seen_instr = seen_instr_ff;
    if (accept) begin
      next_seen_instr = 1'b1;
    end
    else if (jump_i) begin
      next_seen_instr = 1'b0;
    end

    next_wfi_stop = wfi_stop_ff;
    if (wfi_stop_ff && jump_i) begin
      next_wfi_stop = 1'b0;
    end
    else if (accept && dec_rec.wfi) begin
      next_wfi_stop = 1'b1;
    end
  end : next_state

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      dec_valid_ff    <= 1'b0;
      id_ex_ff        <= '0;
      id_ex_ff.pc_dec <= rv_dec_pkg::RESET_PC;
      seen_instr_ff   <= 1'b0;
      wfi_stop_ff     <= 1'b0;
    end
    else begin
      dec_valid_ff  <= next_vld_dec;
      id_ex_ff      <= next_id_ex;
      seen_instr_ff <= next_seen_instr;
      wfi_stop_ff   <= next_wfi_stop;
    end
  end

  // Jump NOP takes priority over the WFI bubble
  always_comb begin
    id_ex_o = id_ex_ff;
    if (jump_i) begin
      id_ex_o        = '0;
      id_ex_o.pc_dec = id_ex_ff.pc_dec;
    end
    else if (wfi_stop_ff) begin
      id_ex_o        = '0;
      id_ex_o.pc_dec = id_ex_ff.pc_dec;
      id_ex_o.wfi    = 1'b1;
    end
  end

  register_file u_register_file (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rs1_addr_i(instr_dec.rs1),
    .rs2_addr_i(instr_dec.rs2),
    .wb_i      (wb_i),
    .re_i      (id_ready_i),
    .rs1_data_o(rs1_data_o),
    .rs2_data_o(rs2_data_o)
  );

endmodule

//--- rtl/register_file.sv
/*
 * Integer register file
 * 32 x 32 bits, two registered read ports and one write port, x0 reads zero
 */
`timescale 1ns/1ps

module register_file (
  input  logic               clk,
  input  logic               rst_n_i,
  input  rv_dec_pkg::raddr_t rs1_addr_i,
  input  rv_dec_pkg::raddr_t rs2_addr_i,
  input  rv_dec_pkg::s_wb_t  wb_i,
  input  logic               re_i,
  output rv_dec_pkg::rdata_t rs1_data_o,
  output rv_dec_pkg::rdata_t rs2_data_o
);
  // x0 has no storage
  rv_dec_pkg::rdata_t regs_ff [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_ff[i] <= '0;
      end
    end
    else if (wb_i.we_rd && (wb_i.rd_addr != '0)) begin
      regs_ff[wb_i.rd_addr] <= wb_i.rd_data;
    end
  end

  // No bypass, a same-edge write is seen one read later
  always_ff @(posedge clk) begin
    if (re_i) begin
      rs1_data_o <= (rs1_addr_i == '0) ? '0 : regs_ff[rs1_addr_i];
      rs2_data_o <= (rs2_addr_i == '0) ? '0 : regs_ff[rs2_addr_i];
    end
  end

endmodule

//--- rtl/rv_dec_pkg.sv
/*
 * RV32I decode definitions
 * Major opcodes, operand and LSU encodings, the records passed between
 * fetch, decode, execute and writeback, and the immediate builder
 */
package rv_dec_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;
  typedef logic [XLEN-1:0] rdata_t;
  typedef logic [XLEN-1:0] instr_raw_t;
  typedef logic [4:0]      raddr_t;

  localparam pc_t RESET_PC = 32'h0000_0000;

  // funct3 of the privileged group and its reserved neighbour
  localparam logic [2:0] F3_PRIV = 3'b000;
  localparam logic [2:0] F3_RSVD = 3'b100;

  // funct7 codes
  localparam logic [6:0] F7_ALT  = 7'h20;
  localparam logic [6:0] F7_MRET = 7'h18;
  localparam logic [6:0] F7_WFI  = 7'h08;

  // rs2 field of the privileged instructions
  localparam raddr_t RS2_ECALL  = 5'd0;
  localparam raddr_t RS2_EBREAK = 5'd1;
  localparam raddr_t RS2_MRET   = 5'd2;
  localparam raddr_t RS2_WFI    = 5'd5;

  typedef enum logic [6:0] {
    RV_OP_IMM   = 7'b0010011,
    RV_LUI      = 7'b0110111,
    RV_AUIPC    = 7'b0010111,
    RV_OP       = 7'b0110011,
    RV_JAL      = 7'b1101111,
    RV_JALR     = 7'b1100111,
    RV_BRANCH   = 7'b1100011,
    RV_LOAD     = 7'b0000011,
    RV_STORE    = 7'b0100011,
    RV_MISC_MEM = 7'b0001111,
    RV_SYSTEM   = 7'b1110011
  } opcode_t;

  typedef struct packed {
    logic [6:0] f7;
    raddr_t     rs2;
    raddr_t     rs1;
    logic [2:0] f3;
    raddr_t     rd;
    opcode_t    op;
  } s_instr_t;

  typedef enum logic [1:0] {REG_RF, IMM, PC, ZERO} op_sel_t;

  typedef enum logic [1:0] {LSU_NONE, LSU_LOAD, LSU_STORE} lsu_t;

  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_w_t;

  typedef enum logic [2:0] {I_IMM, S_IMM, B_IMM, U_IMM, J_IMM, CSR_IMM} imm_kind_t;

  typedef struct packed {
    logic       active;
    instr_raw_t mtval;
    pc_t        pc_addr;
  } s_trap_t;

  typedef struct packed {
    logic [1:0]  op;
    logic [11:0] addr;
    logic        rs1_is_x0;
  } s_csr_t;

  typedef struct packed {
    logic   we_rd;
    raddr_t rd_addr;
    rdata_t rd_data;
  } s_wb_t;

  typedef struct packed {
    logic       jump;
    logic       branch;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       wfi;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       rshift;     // 1 selects arithmetic right shift
    op_sel_t    rs1_op;
    op_sel_t    rs2_op;
    raddr_t     rs1_addr;
    raddr_t     rs2_addr;
    raddr_t     rd_addr;
    logic       we_rd;
    rdata_t     imm;
    lsu_t       lsu;
    lsu_w_t     lsu_w;
    s_csr_t     csr;
    s_trap_t    trap;
    pc_t        pc_dec;
  } s_id_ex_t;

  function automatic rdata_t gen_imm(instr_raw_t instr, imm_kind_t kind);
    rdata_t imm;
    case (kind)
      I_IMM:   imm = {{20{instr[31]}}, instr[31:20]};
      S_IMM:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      B_IMM:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      U_IMM:   imm = {instr[31:12], 12'b0};
      J_IMM:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      // zimm of the CSR immediate forms, zero extended
      CSR_IMM: imm = {27'b0, instr[19:15]};
      default: imm = '0;
    endcase
    return imm;
  endfunction

endpackage
